// ==== rtl/hazardPkg.sv ====
package hazardPkg;

	typedef logic [4:0]  regIdxT;	// GPR number, r0 never forwards
	typedef logic [31:0] wordT;

	// Instruction sitting in ID
	typedef struct packed {
		regIdxT rs;
		regIdxT rt;
		wordT   pc;
		logic   bjOp;	// Branch/jump compared in ID
		wordT   rsData;	// Straight from register file
		wordT   rtData;
	} idStageT;

	// Instruction sitting in EX
	typedef struct packed {
		regIdxT rs;
		regIdxT rt;
		wordT   pc;
		logic   dmRd;	// Load
		logic   cp0Rd;	// mfc0
		logic   rfWr;
		wordT   rsData;
		wordT   rtData;
	} exStageT;

	typedef struct packed {
		regIdxT rd;
		regIdxT rt;
		logic   rfWr;
		logic   dmRd;
		logic   cp0Rd;
		logic   ex;	// Exception taken here
		logic   eretFlush;
		wordT   result;
	} memStageT;

	typedef struct packed {
		regIdxT rd;
		logic   rfWr;
		wordT   result;
	} wbStageT;

endpackage

// ==== rtl/ctrlPkg.sv ====
package ctrlPkg;

	// Operand source for the EX muxes
	typedef enum logic [1:0] {
		FWD_REG = 2'b00,
		FWD_MEM = 2'b01,
		FWD_WB  = 2'b10
	} fwdSelT;

	typedef struct packed {
		fwdSelT exRsSel;
		fwdSelT exRtSel;
		logic   idRsMem;	// Branch rs from MEM result
		logic   idRtMem;
	} fwdSelsT;

	// Front-end control word
	typedef struct packed {
		logic pcWr;
		logic ifIdWr;
		logic instEn;	// Instruction memory enable
		logic bubble;	// Nop into ID/EX
	} pipeCtrlT;

	localparam pipeCtrlT PIPE_RUN = '{
		pcWr:   1'b1,
		ifIdWr: 1'b1,
		instEn: 1'b1,
		bubble: 1'b0
	};

	localparam pipeCtrlT PIPE_STALL = ~PIPE_RUN;

endpackage

// ==== rtl/bypassUnit.sv ====
`timescale 1ns/1ns

module bypassUnit (
	input  logic               clk,
	input  hazardPkg::idStageT  idStage,
	input  hazardPkg::exStageT  exStage,
	input  hazardPkg::memStageT memStage,
	input  hazardPkg::wbStageT  wbStage,
	output ctrlPkg::fwdSelsT    fwdSels
);

	logic exRsMem;
	logic exRtMem;
	logic exRsWb;
	logic exRtWb;

	// Writer hit on a source register, r0 excluded
	function automatic logic wrHit(
		input logic              wr,
		input hazardPkg::regIdxT rd,
		input hazardPkg::regIdxT src
	);
		return wr && (rd != '0) && (rd == src);
	endfunction

	assign exRsMem = wrHit(memStage.rfWr, memStage.rd, exStage.rs);
	assign exRtMem = wrHit(memStage.rfWr, memStage.rd, exStage.rt);
	assign exRsWb  = wrHit(wbStage.rfWr, wbStage.rd, exStage.rs);
	assign exRtWb  = wrHit(wbStage.rfWr, wbStage.rd, exStage.rt);

	always_comb begin
		if (exRsMem)
			fwdSels.exRsSel = ctrlPkg::FWD_MEM;	// Youngest writer wins
		else if (exRsWb)
			fwdSels.exRsSel = ctrlPkg::FWD_WB;
		else
			fwdSels.exRsSel = ctrlPkg::FWD_REG;

		if (exRtMem)
			fwdSels.exRtSel = ctrlPkg::FWD_MEM;
		else if (exRtWb)
			fwdSels.exRtSel = ctrlPkg::FWD_WB;
		else
			fwdSels.exRtSel = ctrlPkg::FWD_REG;

		// Branch compare only bypasses from MEM
		fwdSels.idRsMem = idStage.bjOp && wrHit(memStage.rfWr, memStage.rd, idStage.rs);
		fwdSels.idRtMem = idStage.bjOp && wrHit(memStage.rfWr, memStage.rd, idStage.rt);
	end

	aRsMemFirst: assert property (
		@(posedge clk) exRsMem |-> (fwdSels.exRsSel != ctrlPkg::FWD_WB)
	) else $error("exRsSel took WB over a matching MEM writer");

	aRtMemFirst: assert property (
		@(posedge clk) exRtMem |-> (fwdSels.exRtSel != ctrlPkg::FWD_WB)
	) else $error("exRtSel took WB over a matching MEM writer");

endmodule

// ==== rtl/stallUnit.sv ====
`timescale 1ns/1ns

module stallUnit (
	input  logic               clk,
	input  logic               rst_sign,
	input  hazardPkg::idStageT  idStage,
	input  hazardPkg::exStageT  exStage,
	input  hazardPkg::memStageT memStage,
	input  logic               busy,
	input  logic               rhlVisit,
	output ctrlPkg::pipeCtrlT   stallCtrl
);

	logic exRtUsed;	// ID reads the EX rt
	logic memRtUsed;
	logic flush;
	logic hlWait;
	logic loadUse;
	logic bjMemLoad;
	logic bjExWr;
	logic stall;

	assign exRtUsed  = (exStage.rt == idStage.rs) || (exStage.rt == idStage.rt);
	assign memRtUsed = (memStage.rt == idStage.rs) || (memStage.rt == idStage.rt);

	assign flush  = memStage.ex || memStage.eretFlush;
	assign hlWait = busy && rhlVisit;	// mul/div still running

	// Same pc means the stall was already taken for this pair
	assign loadUse = (exStage.dmRd || exStage.cp0Rd) && exRtUsed
		&& (idStage.pc != exStage.pc);

	assign bjMemLoad = idStage.bjOp && memStage.rfWr
		&& (memStage.dmRd || memStage.cp0Rd) && memRtUsed;

	assign bjExWr = idStage.bjOp && exStage.rfWr && exRtUsed;

	always_comb begin
		if (rst_sign)
			stall = 1'b1;
		else if (flush)
			stall = 1'b0;	// Redirect to handler must proceed
		else if (hlWait)
			stall = 1'b1;
		else if (loadUse)
			stall = 1'b1;
		else if (bjMemLoad)
			stall = 1'b1;
		else if (bjExWr)
			stall = 1'b1;
		else
			stall = 1'b0;
	end

	assign stallCtrl = stall ? ctrlPkg::PIPE_STALL : ctrlPkg::PIPE_RUN;

	aCtrlConsistent: assert property (
		@(posedge clk)
		(stallCtrl.pcWr == stallCtrl.ifIdWr) && (stallCtrl.bubble == !stallCtrl.pcWr)
	) else $error("stall control word inconsistent");

endmodule

// ==== rtl/hazardCombine.sv ====
`timescale 1ns/1ns

module hazardCombine (
	input  logic               clk,
	input  ctrlPkg::fwdSelsT    fwdSels,
	input  ctrlPkg::pipeCtrlT   stallCtrl,
	input  hazardPkg::idStageT  idStage,
	input  hazardPkg::exStageT  exStage,
	input  hazardPkg::memStageT memStage,
	input  hazardPkg::wbStageT  wbStage,
	output hazardPkg::wordT     exRsVal,
	output hazardPkg::wordT     exRtVal,
	output hazardPkg::wordT     idRsVal,
	output hazardPkg::wordT     idRtVal,
	output ctrlPkg::fwdSelsT    fwdSelsOut,
	output ctrlPkg::pipeCtrlT   pipeCtrl
);

	logic bjExHit;

	// Three-way EX operand mux
	function automatic hazardPkg::wordT pickEx(
		input ctrlPkg::fwdSelT sel,
		input hazardPkg::wordT regData,
		input hazardPkg::wordT memData,
		input hazardPkg::wordT wbData
	);
		case (sel)
			ctrlPkg::FWD_MEM: return memData;
			ctrlPkg::FWD_WB:  return wbData;
			default:          return regData;
		endcase
	endfunction

	always_comb begin
		exRsVal = pickEx(fwdSels.exRsSel, exStage.rsData, memStage.result, wbStage.result);
		exRtVal = pickEx(fwdSels.exRtSel, exStage.rtData, memStage.result, wbStage.result);
		idRsVal = fwdSels.idRsMem ? memStage.result : idStage.rsData;
		idRtVal = fwdSels.idRtMem ? memStage.result : idStage.rtData;
	end

	assign fwdSelsOut = fwdSels;
	assign pipeCtrl   = stallCtrl;

	// Branch source still being computed in EX
	assign bjExHit = idStage.bjOp && exStage.rfWr
		&& ((exStage.rt == idStage.rs) || (exStage.rt == idStage.rt));

	// A running branch must never read a result EX has not produced,
	// unless MEM is redirecting the pipe anyway
	aBranchSafe: assert property (
		@(posedge clk)
		(pipeCtrl.pcWr && !(memStage.ex || memStage.eretFlush)) |-> !bjExHit
	) else $error("branch ran past an EX writer it depends on");

endmodule

// ==== rtl/hazardTop.sv ====
`timescale 1ns/1ns

module hazardTop (
	input  logic               clk,
	input  logic               rst_sign,
	input  hazardPkg::idStageT  idStage,
	input  hazardPkg::exStageT  exStage,
	input  hazardPkg::memStageT memStage,
	input  hazardPkg::wbStageT  wbStage,
	input  logic               busy,
	input  logic               rhlVisit,
	output hazardPkg::wordT     exRsVal,
	output hazardPkg::wordT     exRtVal,
	output hazardPkg::wordT     idRsVal,
	output hazardPkg::wordT     idRtVal,
	output ctrlPkg::fwdSelsT    fwdSels,
	output ctrlPkg::pipeCtrlT   pipeCtrl
);

	ctrlPkg::fwdSelsT  rawSels;
	ctrlPkg::pipeCtrlT stallCtrl;

	bypassUnit i_bypass (
		.clk      (clk),
		.idStage  (idStage),
		.exStage  (exStage),
		.memStage (memStage),
		.wbStage  (wbStage),
		.fwdSels  (rawSels)
	);

	stallUnit i_stall (
		.clk       (clk),
		.rst_sign  (rst_sign),
		.idStage   (idStage),
		.exStage   (exStage),
		.memStage  (memStage),
		.busy      (busy),
		.rhlVisit  (rhlVisit),
		.stallCtrl (stallCtrl)
	);

	hazardCombine i_combine (
		.clk        (clk),
		.fwdSels    (rawSels),
		.stallCtrl  (stallCtrl),
		.idStage    (idStage),
		.exStage    (exStage),
		.memStage   (memStage),
		.wbStage    (wbStage),
		.exRsVal    (exRsVal),
		.exRtVal    (exRtVal),
		.idRsVal    (idRsVal),
		.idRtVal    (idRtVal),
		.fwdSelsOut (fwdSels),
		.pipeCtrl   (pipeCtrl)
	);

endmodule

// ==== sim/tbTable.svh ====
`ifndef TB_TABLE_SVH
`define TB_TABLE_SVH

// One test step: stimulus, then expected results
typedef struct packed {
	logic [8*12-1:0]     name;
	hazardPkg::idStageT  id;
	hazardPkg::exStageT  ex;
	hazardPkg::memStageT mem;
	hazardPkg::wbStageT  wb;
	logic                busy;
	logic                rhlVisit;
	logic                rst;
	hazardPkg::wordT     exRs;
	hazardPkg::wordT     exRt;
	hazardPkg::wordT     idRs;
	hazardPkg::wordT     idRt;
	ctrlPkg::fwdSelsT    sels;
	ctrlPkg::pipeCtrlT   ctrl;
} tableEntryT;

localparam int N_ROWS = 16;

localparam hazardPkg::wordT ID_RS_D = 32'h1d00_0aa1;	// Distinct word per source
localparam hazardPkg::wordT ID_RT_D = 32'h1d00_0bb2;
localparam hazardPkg::wordT EX_RS_D = 32'he700_0cc3;
localparam hazardPkg::wordT EX_RT_D = 32'he700_0dd4;
localparam hazardPkg::wordT MEM_RES = 32'h3e30_5aa5;
localparam hazardPkg::wordT WB_RES  = 32'h3b00_a55a;
localparam hazardPkg::wordT PC_A    = 32'h0040_0010;
localparam hazardPkg::wordT PC_B    = 32'h0040_000c;

localparam ctrlPkg::pipeCtrlT RUN_W   = 4'b1110;	// pcWr ifIdWr instEn bubble
localparam ctrlPkg::pipeCtrlT STALL_W = 4'b0001;
localparam ctrlPkg::fwdSelT   F_R     = ctrlPkg::FWD_REG;
localparam ctrlPkg::fwdSelT   F_M     = ctrlPkg::FWD_MEM;
localparam ctrlPkg::fwdSelT   F_W     = ctrlPkg::FWD_WB;

tableEntryT dirTable[N_ROWS];
int         rowFill = 0;

function automatic hazardPkg::idStageT idS(input logic [4:0] rsN, input logic [4:0] rtN,
	input logic [31:0] pcV, input logic bj);
	return '{rs: rsN, rt: rtN, pc: pcV, bjOp: bj, rsData: ID_RS_D, rtData: ID_RT_D};
endfunction

// fl is dmRd cp0Rd rfWr
function automatic hazardPkg::exStageT exS(input logic [4:0] rsN, input logic [4:0] rtN,
	input logic [31:0] pcV, input logic [2:0] fl);
	return '{rs: rsN, rt: rtN, pc: pcV, dmRd: fl[2], cp0Rd: fl[1], rfWr: fl[0],
		rsData: EX_RS_D, rtData: EX_RT_D};
endfunction

// fl is rfWr dmRd cp0Rd ex eretFlush
function automatic hazardPkg::memStageT memS(input logic [4:0] rdN, input logic [4:0] rtN,
	input logic [4:0] fl);
	return '{rd: rdN, rt: rtN, rfWr: fl[4], dmRd: fl[3], cp0Rd: fl[2], ex: fl[1],
		eretFlush: fl[0], result: MEM_RES};
endfunction

function automatic hazardPkg::wbStageT wbS(input logic [4:0] rdN, input logic wr);
	return '{rd: rdN, rfWr: wr, result: WB_RES};
endfunction

// ctl is busy rhlVisit rst, eSels is exRsSel exRtSel idRsMem idRtMem
task automatic addRow(input logic [8*12-1:0] nm, input hazardPkg::idStageT id,
	input hazardPkg::exStageT ex, input hazardPkg::memStageT mem, input hazardPkg::wbStageT wb,
	input logic [2:0] ctl, input hazardPkg::wordT eExRs, input hazardPkg::wordT eExRt,
	input hazardPkg::wordT eIdRs, input hazardPkg::wordT eIdRt, input ctrlPkg::fwdSelsT eSels,
	input ctrlPkg::pipeCtrlT eCtrl);
	dirTable[rowFill] = '{nm, id, ex, mem, wb, ctl[2], ctl[1], ctl[0],
		eExRs, eExRt, eIdRs, eIdRt, eSels, eCtrl};
	rowFill++;
endtask

task automatic loadTable();
	addRow("rst_flush", idS(1, 2, PC_A, 1), exS(3, 2, PC_B, 3'b101), memS(3, 0, 5'b10010),
		wbS(0, 0), 3'b111, MEM_RES, EX_RT_D, ID_RS_D, ID_RT_D, {F_M, F_R, 2'b00}, STALL_W);
	addRow("idle", idS(1, 2, PC_A, 0), exS(3, 4, PC_B, 3'b000), memS(0, 0, 5'b00000),
		wbS(0, 0), 3'b000, EX_RS_D, EX_RT_D, ID_RS_D, ID_RT_D, {F_R, F_R, 2'b00}, RUN_W);
	addRow("mem_over_wb", idS(1, 2, PC_A, 0), exS(3, 3, PC_B, 3'b000), memS(3, 0, 5'b10000),
		wbS(3, 1), 3'b000, MEM_RES, MEM_RES, ID_RS_D, ID_RT_D, {F_M, F_M, 2'b00}, RUN_W);
	addRow("wb_rt", idS(1, 2, PC_A, 0), exS(3, 4, PC_B, 3'b000), memS(3, 0, 5'b10000),
		wbS(4, 1), 3'b000, MEM_RES, WB_RES, ID_RS_D, ID_RT_D, {F_M, F_W, 2'b00}, RUN_W);
	addRow("r0_never", idS(1, 2, PC_A, 0), exS(0, 0, PC_B, 3'b000), memS(0, 0, 5'b10000),
		wbS(0, 1), 3'b000, EX_RS_D, EX_RT_D, ID_RS_D, ID_RT_D, {F_R, F_R, 2'b00}, RUN_W);
	addRow("mem_no_wr", idS(1, 2, PC_A, 0), exS(3, 4, PC_B, 3'b000), memS(3, 0, 5'b00000),
		wbS(3, 1), 3'b000, WB_RES, EX_RT_D, ID_RS_D, ID_RT_D, {F_W, F_R, 2'b00}, RUN_W);
	addRow("br_mem_fwd", idS(5, 6, PC_A, 1), exS(3, 4, PC_B, 3'b000), memS(5, 0, 5'b10000),
		wbS(0, 0), 3'b000, EX_RS_D, EX_RT_D, MEM_RES, ID_RT_D, {F_R, F_R, 2'b10}, RUN_W);
	addRow("br_no_bjop", idS(5, 6, PC_A, 0), exS(3, 4, PC_B, 3'b000), memS(5, 0, 5'b10000),
		wbS(0, 0), 3'b000, EX_RS_D, EX_RT_D, ID_RS_D, ID_RT_D, {F_R, F_R, 2'b00}, RUN_W);
	addRow("load_use", idS(1, 2, PC_A, 0), exS(3, 2, PC_B, 3'b100), memS(0, 0, 5'b00000),
		wbS(0, 0), 3'b000, EX_RS_D, EX_RT_D, ID_RS_D, ID_RT_D, {F_R, F_R, 2'b00}, STALL_W);
	addRow("cp0_use", idS(1, 2, PC_A, 0), exS(3, 1, PC_B, 3'b010), memS(0, 0, 5'b00000),
		wbS(0, 0), 3'b000, EX_RS_D, EX_RT_D, ID_RS_D, ID_RT_D, {F_R, F_R, 2'b00}, STALL_W);
	addRow("ld_same_pc", idS(1, 2, PC_A, 0), exS(3, 2, PC_A, 3'b100), memS(0, 0, 5'b00000),
		wbS(0, 0), 3'b000, EX_RS_D, EX_RT_D, ID_RS_D, ID_RT_D, {F_R, F_R, 2'b00}, RUN_W);
	addRow("br_mem_load", idS(5, 6, PC_A, 1), exS(3, 4, PC_B, 3'b000), memS(6, 6, 5'b11000),
		wbS(0, 0), 3'b000, EX_RS_D, EX_RT_D, ID_RS_D, MEM_RES, {F_R, F_R, 2'b01}, STALL_W);
	addRow("br_ex_wr", idS(5, 6, PC_A, 1), exS(3, 5, PC_B, 3'b001), memS(0, 0, 5'b00000),
		wbS(0, 0), 3'b000, EX_RS_D, EX_RT_D, ID_RS_D, ID_RT_D, {F_R, F_R, 2'b00}, STALL_W);
	addRow("hl_busy", idS(1, 2, PC_A, 0), exS(3, 4, PC_B, 3'b000), memS(0, 0, 5'b00000),
		wbS(0, 0), 3'b110, EX_RS_D, EX_RT_D, ID_RS_D, ID_RT_D, {F_R, F_R, 2'b00}, STALL_W);
	addRow("flush_ex", idS(1, 2, PC_A, 1), exS(3, 2, PC_B, 3'b101), memS(0, 0, 5'b00010),
		wbS(0, 0), 3'b110, EX_RS_D, EX_RT_D, ID_RS_D, ID_RT_D, {F_R, F_R, 2'b00}, RUN_W);
	addRow("flush_eret", idS(1, 2, PC_A, 0), exS(3, 2, PC_B, 3'b100), memS(0, 0, 5'b00001),
		wbS(0, 0), 3'b110, EX_RS_D, EX_RT_D, ID_RS_D, ID_RT_D, {F_R, F_R, 2'b00}, RUN_W);
endtask

`endif

// ==== sim/hazardTb.sv ====
`timescale 1ns/1ns

module hazardTb;

	localparam int RESET_CYCLES = 10;
	localparam int RAND_CYCLES  = 200;

	logic                clk;
	logic                rst_sign;
	hazardPkg::idStageT  idStage;
	hazardPkg::exStageT  exStage;
	hazardPkg::memStageT memStage;
	hazardPkg::wbStageT  wbStage;
	logic                busy;
	logic                rhlVisit;
	hazardPkg::wordT     exRsVal;
	hazardPkg::wordT     exRtVal;
	hazardPkg::wordT     idRsVal;
	hazardPkg::wordT     idRtVal;
	ctrlPkg::fwdSelsT    fwdSels;
	ctrlPkg::pipeCtrlT   pipeCtrl;
	logic [31:0]         rngState;
	int                  errors = 0;
	int                  cycles = 0;

	`include "tbTable.svh"

	localparam int CYCLE_LIMIT = RESET_CYCLES + N_ROWS + RAND_CYCLES + 50;

	hazardTop i_dut (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not end within %0d cycles", CYCLE_LIMIT);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	// Youngest nonzero writer first
	function automatic ctrlPkg::fwdSelT exSource(input hazardPkg::regIdxT src,
		input hazardPkg::memStageT m, input hazardPkg::wbStageT w);
		if (src != 0 && m.rfWr && m.rd == src)
			return ctrlPkg::FWD_MEM;
		if (src != 0 && w.rfWr && w.rd == src)
			return ctrlPkg::FWD_WB;
		return ctrlPkg::FWD_REG;
	endfunction

	function automatic hazardPkg::wordT pick(input ctrlPkg::fwdSelT s,
		input hazardPkg::wordT regV, input tableEntryT e);
		if (s == ctrlPkg::FWD_MEM)
			return e.mem.result;
		return (s == ctrlPkg::FWD_WB) ? e.wb.result : regV;
	endfunction

	function automatic tableEntryT predict(input tableEntryT e);
		tableEntryT p;
		logic ldHit;
		logic brHit;
		logic stall;
		p = e;
		p.sels.exRsSel = exSource(e.ex.rs, e.mem, e.wb);
		p.sels.exRtSel = exSource(e.ex.rt, e.mem, e.wb);
		p.sels.idRsMem = e.id.bjOp && (exSource(e.id.rs, e.mem, '0) == ctrlPkg::FWD_MEM);
		p.sels.idRtMem = e.id.bjOp && (exSource(e.id.rt, e.mem, '0) == ctrlPkg::FWD_MEM);
		p.exRs = pick(p.sels.exRsSel, e.ex.rsData, e);
		p.exRt = pick(p.sels.exRtSel, e.ex.rtData, e);
		p.idRs = p.sels.idRsMem ? e.mem.result : e.id.rsData;
		p.idRt = p.sels.idRtMem ? e.mem.result : e.id.rtData;
		ldHit = (e.ex.dmRd || e.ex.cp0Rd) && (e.id.pc != e.ex.pc)
			&& (e.ex.rt == e.id.rs || e.ex.rt == e.id.rt);
		brHit = e.id.bjOp && ((e.mem.rfWr && (e.mem.dmRd || e.mem.cp0Rd)
			&& (e.mem.rt == e.id.rs || e.mem.rt == e.id.rt))
			|| (e.ex.rfWr && (e.ex.rt == e.id.rs || e.ex.rt == e.id.rt)));
		if (e.rst)
			stall = 1'b1;
		else if (e.mem.ex || e.mem.eretFlush)
			stall = 1'b0;
		else
			stall = (e.busy && e.rhlVisit) || ldHit || brHit;
		p.ctrl = stall ? STALL_W : RUN_W;
		return p;
	endfunction

	// Register numbers kept to 0..3 so hits are frequent
	function automatic tableEntryT randomRow(input logic rstVal);
		tableEntryT e;
		logic [31:0] r;
		logic [31:0] f;
		r = nextRand();
		f = nextRand();
		e = '0;
		e.name = "random";
		e.id = idS({3'b0, r[1:0]}, {3'b0, r[3:2]}, r[14] ? PC_A : PC_B, f[0]);
		e.ex = exS({3'b0, r[5:4]}, {3'b0, r[7:6]}, r[15] ? PC_A : PC_B,
			{f[1], f[2] & f[3], f[4]});
		e.mem = memS({3'b0, r[9:8]}, {3'b0, r[11:10]},
			{f[5], f[6], f[7] & f[8], &f[11:9], &f[14:12]});
		e.wb = wbS({3'b0, r[13:12]}, f[15]);
		e.id.rsData   = nextRand();
		e.id.rtData   = nextRand();
		e.ex.rsData   = nextRand();
		e.ex.rtData   = nextRand();
		e.mem.result  = nextRand();
		e.wb.result   = nextRand();
		e.busy        = f[16];
		e.rhlVisit    = f[17];
		e.rst         = rstVal;
		return predict(e);
	endfunction

	task automatic checkVal(input string nm, input string what, input logic [31:0] expV,
		input logic [31:0] actV);
		assert (actV === expV) else begin
			errors++;
			$display("[ERROR] %s %s expected %h actual %h", nm, what, expV, actV);
		end
	endtask

	task automatic checkRow(input tableEntryT e);
		string nm;
		nm = string'(e.name);
		checkVal(nm, "exRsVal", e.exRs, exRsVal);
		checkVal(nm, "exRtVal", e.exRt, exRtVal);
		checkVal(nm, "idRsVal", e.idRs, idRsVal);
		checkVal(nm, "idRtVal", e.idRt, idRtVal);
		checkVal(nm, "fwdSels", e.sels, fwdSels);
		checkVal(nm, "pipeCtrl", e.ctrl, pipeCtrl);
	endtask

	// Called just after a rising edge, checks at the next one
	task automatic runRow(input tableEntryT e);
		#1;
		idStage  = e.id;
		exStage  = e.ex;
		memStage = e.mem;
		wbStage  = e.wb;
		busy     = e.busy;
		rhlVisit = e.rhlVisit;
		rst_sign = e.rst;
		@(posedge clk);
		checkRow(e);
	endtask

	initial begin
		rst_sign = 1'b1;
		idStage  = '0;
		exStage  = '0;
		memStage = '0;
		wbStage  = '0;
		busy     = 1'b0;
		rhlVisit = 1'b0;
		rngState = 32'h68e1_3107;
		loadTable();
		assert (rowFill == N_ROWS) else begin
			errors++;
			$display("Directed table holds %0d rows instead of %0d", rowFill, N_ROWS);
		end
		@(posedge clk);
		repeat (RESET_CYCLES) runRow(randomRow(1'b1));	// Stages random, reset wins
		for (int i = 0; i < N_ROWS; i++)
			runRow(dirTable[i]);
		repeat (RAND_CYCLES) runRow(randomRow(1'b0));
		$display("Summary: %0d directed rows, %0d random cycles, %0d errors",
			N_ROWS, RAND_CYCLES, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+sim
rtl/hazardPkg.sv
rtl/ctrlPkg.sv
rtl/bypassUnit.sv
rtl/stallUnit.sv
rtl/hazardCombine.sv
rtl/hazardTop.sv
sim/hazardTb.sv
